/* hdl/fm_gain.sv */
module fm_gain
    import snd_pkg::*;
(
    input  logic        sample,
    input  logic        arst_n,
    input  logic        snd_cen,
    input  snd_stereo_t fm_snd,
    input  fx_level_e   fx_level,
    output snd_stereo_t fm_out,
    output logic        fm_valid
);

    snd_stereo_t scaled;

    // Gain of one channel for the selected volume
    function automatic snd_sample_t apply_gain(snd_sample_t x, fx_level_e lvl);
        case (lvl)
            fx_very_high: begin
                // Doubling overflows when the two top bits differ
                if (x[snd_w-1] != x[snd_w-2])
                    return x[snd_w-1] ? snd_min : snd_max;
                else
                    return x <<< 1;
            end
            fx_very_low: return x >>> 2;
            fx_low:      return x >>> 1;
            default:     return x;
        endcase
    endfunction

    always_comb begin
        scaled.left  = apply_gain(fm_snd.left, fx_level);
        scaled.right = apply_gain(fm_snd.right, fx_level);
    end

    always_ff @(posedge sample or negedge arst_n) begin
        if (!arst_n) begin
            fm_valid <= 1'b0;
        end else begin
            fm_valid <= snd_cen;
        end
    end

    // Held between strobes
    always_ff @(posedge sample) begin
        if (snd_cen) begin
            fm_out <= scaled;
        end
    end

    a_fx_known: assert property (
        @(posedge sample) disable iff (!arst_n)
        snd_cen |-> !$isunknown(fx_level)
    );

endmodule

/* hdl/osd_pkg.sv */
package osd_pkg;

    import snd_pkg::*;

    // Menu view of the status word
    typedef struct packed {
        logic [15:0] dip_hi;
        logic [5:0]  spare_hi;
        logic        fm_off;
        logic        psg_off;
        fx_level_e   fx_level;
        logic [1:0]  video_mode;
        logic        rotate;
        logic        flip;
        logic        spare_lo;
        logic        rst_req;
    } osd_opts_t;

    // Switch view, upper half carries the DIP bytes
    typedef struct packed {
        logic [7:0]  dip_b;
        logic [7:0]  dip_a;
        logic [15:0] menu_lo;
    } osd_dip_t;

    typedef union packed {
        osd_opts_t opts;
        osd_dip_t  dip;
    } osd_status_u;

endpackage

/* hdl/psg_dcrm.sv */
module psg_dcrm
    import snd_pkg::*;
#(
    parameter int dc_shift = 4
) (
    input  logic             sample,
    input  logic             arst_n,
    input  logic             snd_cen,
    input  logic [psg_w-1:0] psg_raw,
    output snd_sample_t      psg_out,
    output logic             psg_valid
);

    // Two guard bits above the sample width
    localparam int avg_w = snd_w + 2;

    logic signed [avg_w-1:0] x;
    logic signed [avg_w-1:0] avg;
    logic signed [avg_w:0]   diff;
    logic signed [avg_w:0]   step;
    snd_sample_t             diff_sat;

    if (dc_shift < 2 || dc_shift > 8) begin : g_bad_shift
        $error("psg_dcrm: dc_shift must lie in 2..8");
    end

    // Raw PSG level scaled up to full range, always positive
    assign x    = {{(avg_w-snd_w){1'b0}}, psg_raw, {(snd_w-psg_w){1'b0}}};
    assign diff = x - avg;
    assign step = diff >>> dc_shift;

    always_comb begin
        if (diff > snd_max)
            diff_sat = snd_max;
        else if (diff < snd_min)
            diff_sat = snd_min;
        else
            diff_sat = diff[snd_w-1:0];
    end

    // Running average tracks the DC level
    always_ff @(posedge sample or negedge arst_n) begin
        if (!arst_n) begin
            avg       <= '0;
            psg_valid <= 1'b0;
        end else begin
            psg_valid <= snd_cen;
            if (snd_cen) begin
                avg <= avg_w'(avg + step);
            end
        end
    end

    always_ff @(posedge sample) begin
        if (snd_cen) begin
            psg_out <= diff_sat;
        end
    end

endmodule

/* hdl/sd_dac.sv */
module sd_dac
    import snd_pkg::*;
(
    input  logic        sample,
    input  logic        arst_n,
    input  snd_sample_t din,
    output logic        dout
);

    logic [snd_w-1:0] din_u;
    logic [snd_w:0]   acc;

    // Offset binary, same as adding 32768
    assign din_u = {~din[snd_w-1], din[snd_w-2:0]};

    always_ff @(posedge sample or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
        end else begin
            acc <= {1'b0, acc[snd_w-1:0]} + {1'b0, din_u};
        end
    end

    // Carry density follows the input level
    assign dout = acc[snd_w];

    a_din_known: assert property (
        @(posedge sample) disable iff (!arst_n)
        !$isunknown(din)
    );

endmodule

/* hdl/snd_board_top.sv */
module snd_board_top
    import snd_pkg::*;
    import osd_pkg::*;
#(
    parameter int dc_shift = 4
) (
    input  logic             sample,
    input  logic             arst_n,
    input  logic             snd_cen,
    input  snd_stereo_t      fm_snd,
    input  logic [psg_w-1:0] psg_raw,
    input  osd_status_u      status,
    output logic             audio_l,
    output logic             audio_r,
    output snd_stereo_t      mix,
    output logic             mix_valid,
    output logic [7:0]       dip_a,
    output logic [7:0]       dip_b
);

    snd_stereo_t fm_out;
    logic        fm_valid;
    snd_sample_t psg_out;
    logic        psg_valid;

    // Upper half of the status word seen as switches
    assign dip_a = status.dip.dip_a;
    assign dip_b = status.dip.dip_b;

    fm_gain u_fm (
        .sample   ( sample                 ),
        .arst_n   ( arst_n                 ),
        .snd_cen  ( snd_cen                ),
        .fm_snd   ( fm_snd                 ),
        .fx_level ( status.opts.fx_level   ),
        .fm_out   ( fm_out                 ),
        .fm_valid ( fm_valid               )
    );

    psg_dcrm #(
        .dc_shift ( dc_shift               )
    ) u_psg (
        .sample    ( sample                ),
        .arst_n    ( arst_n                ),
        .snd_cen   ( snd_cen               ),
        .psg_raw   ( psg_raw               ),
        .psg_out   ( psg_out               ),
        .psg_valid ( psg_valid             )
    );

    snd_mix u_mix (
        .sample    ( sample                ),
        .arst_n    ( arst_n                ),
        .fm_out    ( fm_out                ),
        .fm_valid  ( fm_valid              ),
        .psg_out   ( psg_out               ),
        .psg_valid ( psg_valid             ),
        .fm_off    ( status.opts.fm_off    ),
        .psg_off   ( status.opts.psg_off   ),
        .mix       ( mix                   ),
        .mix_valid ( mix_valid             )
    );

    // One converter per audio pin
    sd_dac u_dac_l (
        .sample ( sample                   ),
        .arst_n ( arst_n                   ),
        .din    ( mix.left                 ),
        .dout   ( audio_l                  )
    );

    sd_dac u_dac_r (
        .sample ( sample                   ),
        .arst_n ( arst_n                   ),
        .din    ( mix.right                ),
        .dout   ( audio_r                  )
    );

endmodule

/* hdl/snd_mix.sv */
module snd_mix
    import snd_pkg::*;
(
    input  logic        sample,
    input  logic        arst_n,
    input  snd_stereo_t fm_out,
    input  logic        fm_valid,
    input  snd_sample_t psg_out,
    input  logic        psg_valid,
    input  logic        fm_off,
    input  logic        psg_off,
    output snd_stereo_t mix,
    output logic        mix_valid
);

    snd_stereo_t fm_en;
    snd_sample_t psg_en;
    snd_stereo_t sum;

    function automatic snd_sample_t sat_add(snd_sample_t a, snd_sample_t b);
        logic signed [snd_w:0] s;
        s = a + b;
        if (s[snd_w] != s[snd_w-1])
            return s[snd_w] ? snd_min : snd_max;
        else
            return s[snd_w-1:0];
    endfunction

    // Disabled sources count as silence
    always_comb begin
        fm_en  = fm_off ? '0 : fm_out;
        psg_en = psg_off ? '0 : psg_out;
    end

    always_comb begin
        sum.left  = sat_add(fm_en.left, psg_en);
        sum.right = sat_add(fm_en.right, psg_en);
    end

    always_ff @(posedge sample or negedge arst_n) begin
        if (!arst_n) begin
            mix       <= '0;
            mix_valid <= 1'b0;
        end else begin
            mix_valid <= fm_valid;
            if (fm_valid) begin
                mix <= sum;
            end
        end
    end

    // FM and PSG stages run off the same strobe, so the mixer needs only one
    a_valid_aligned: assert property (
        @(posedge sample) disable iff (!arst_n)
        fm_valid == psg_valid
    );

endmodule

/* hdl/snd_pkg.sv */
package snd_pkg;

    // Sample widths
    localparam int snd_w = 16;
    localparam int psg_w = 10;

    typedef logic signed [snd_w-1:0] snd_sample_t;

    typedef struct packed {
        snd_sample_t left;
        snd_sample_t right;
    } snd_stereo_t;

    // Saturation limits shared by every stage
    localparam snd_sample_t snd_max = 16'sh7fff;
    localparam snd_sample_t snd_min = 16'sh8000;

    // Effects volume, same order as the menu entry
    typedef enum logic [1:0] {
        fx_high      = 2'd0,
        fx_very_high = 2'd1,
        fx_very_low  = 2'd2,
        fx_low       = 2'd3
    } fx_level_e;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build and run the sound path testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_snd_board_top -f snd_board_top.f -o sim_tb

# The run may stop with a nonzero status; the log decides
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
grep -q "TEST OK" sim.log

/* snd_board_top.f */
hdl/snd_pkg.sv
hdl/osd_pkg.sv
hdl/fm_gain.sv
hdl/psg_dcrm.sv
hdl/snd_mix.sv
hdl/sd_dac.sv
hdl/snd_board_top.sv
testbench/tb_snd_board_top.sv

/* testbench/tb_snd_board_top.sv */
module tb_snd_board_top
    import snd_pkg::*;
    import osd_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int dc_shift = 4;
    localparam int drain    = 4;
    localparam int n_fm_gap = 16;
    localparam int n_fm_b2b = 8;
    localparam int n_dc     = 32;
    localparam int n_en     = 24;
    localparam int n_dip    = 32;
    // Phase lengths in cycles: reset, FM, DC, enables, density, DIP
    localparam int total_cycles = 7 + 4 * (n_fm_gap * 4 + n_fm_b2b + drain)
        + (2 * n_dc) * 2 + drain + (2 * n_en) * 2 + drain
        + 3 * (drain + 1026) + n_dip;

    logic             sample = 1'b0;
    logic             arst_n;
    logic             snd_cen;
    snd_stereo_t      fm_snd;
    logic [psg_w-1:0] psg_raw;
    osd_status_u      status;
    logic             audio_l;
    logic             audio_r;
    snd_stereo_t      mix;
    logic             mix_valid;
    logic [7:0]       dip_a;
    logic [7:0]       dip_b;

    logic [31:0] rng;
    int          dc_avg;
    logic        cen_seen;
    snd_stereo_t exp_q[$];
    snd_stereo_t exp_head;

    snd_board_top #(.dc_shift(dc_shift)) UUT (.*);

    always #10 sample = ~sample;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        return v ^ (v << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic int clamp16(input int v);
        if (v > 32767) return 32767;
        else if (v < -32768) return -32768;
        return v;
    endfunction

    // Effects volume codes: 0 x1, 1 x2, 2 x1/4, 3 x1/2
    function automatic int scale_fm(input int x, input logic [1:0] lvl);
        case (lvl)
            2'd1: return clamp16(x * 2);
            2'd2: return x >>> 2;
            2'd3: return x >>> 1;
            default: return x;
        endcase
    endfunction

    // DC filter step, output uses the average before the update
    task automatic model_psg(input logic [psg_w-1:0] raw, output int y);
        int d;
        d = int'(raw) * 64 - dc_avg;
        y = clamp16(d);
        dc_avg = dc_avg + (d >>> dc_shift);
    endtask

    // Menu bits: fx_level 7:6, psg_off 8, fm_off 9
    task automatic set_menu(input logic [1:0] lvl, input logic psg_off, input logic fm_off);
        logic [31:0] w;
        w = next_rand();
        w[7:6] = lvl;
        w[8] = psg_off;
        w[9] = fm_off;
        status = w;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge sample);
            #2;
        end
    endtask

    task automatic send_sample(input snd_stereo_t f, input logic [psg_w-1:0] p, input int gap);
        logic [31:0] w;
        int          psg_y;
        int          psg_v;
        snd_stereo_t e;
        w = status;
        model_psg(p, psg_y);
        psg_v = w[8] ? 0 : psg_y;
        e.left  = 16'(clamp16((w[9] ? 0 : scale_fm(int'(f.left), w[7:6])) + psg_v));
        e.right = 16'(clamp16((w[9] ? 0 : scale_fm(int'(f.right), w[7:6])) + psg_v));
        exp_q.push_back(e);
        cen_seen = 1'b1;
        snd_cen  = 1'b1;
        fm_snd   = f;
        psg_raw  = p;
        wait_cycles(1);
        snd_cen = 1'b0;
        wait_cycles(gap);
    endtask

    // Ones on each pin over 1024 cycles, scaled by 64 against the offset level
    task automatic check_density(input snd_sample_t l, input snd_sample_t r);
        int ones_l;
        int ones_r;
        int u_l;
        int u_r;
        ones_l = 0;
        ones_r = 0;
        u_l = int'(l) + 32768;
        u_r = int'(r) + 32768;
        set_menu(2'd0, 1'b1, 1'b0);
        send_sample({l, r}, psg_raw, drain);
        repeat (1024) begin
            @(negedge sample);
            ones_l += int'(audio_l);
            ones_r += int'(audio_r);
        end
        wait_cycles(1);
        assert (ones_l * 64 - u_l >= -64 && ones_l * 64 - u_l <= 64)
            else fail_now($sformatf("CHECK FAILED audio_l exp %h act %h", u_l / 64, ones_l));
        assert (ones_r * 64 - u_r >= -64 && ones_r * 64 - u_r <= 64)
            else fail_now($sformatf("CHECK FAILED audio_r exp %h act %h", u_r / 64, ones_r));
    endtask

    // Next expected mix, settled well before the checking edge
    always @(negedge sample) begin
        if (arst_n && mix_valid) begin
            if (exp_q.size() == 0)
                fail_now("mix_valid pulsed with no sample in flight");
            else
                exp_head = exp_q.pop_front();
        end
    end

    a_reset_audio: assert property (@(posedge sample) !arst_n |-> !audio_l && !audio_r)
        else fail_now($sformatf("CHECK FAILED audio_l,audio_r exp 0,0 act %h,%h",
            $sampled(audio_l), $sampled(audio_r)));

    a_idle_mix: assert property (@(posedge sample) !cen_seen |-> !mix_valid && mix == '0)
        else fail_now($sformatf("CHECK FAILED mix_valid,mix exp 0,00000000 act %h,%h",
            $sampled(mix_valid), $sampled(mix)));

    a_latency: assert property (
        @(posedge sample) disable iff (!arst_n) mix_valid == $past(snd_cen, 2)
    ) else fail_now($sformatf("CHECK FAILED mix_valid exp %h act %h",
        !$sampled(mix_valid), $sampled(mix_valid)));

    a_mix_value: assert property (
        @(posedge sample) disable iff (!arst_n) mix_valid |-> mix == exp_head
    ) else fail_now($sformatf("CHECK FAILED mix exp %h act %h",
        $sampled(exp_head), $sampled(mix)));

    a_dip_a: assert property (@(posedge sample) dip_a == status[23:16])
        else fail_now($sformatf("CHECK FAILED dip_a exp %h act %h",
            $sampled(status[23:16]), $sampled(dip_a)));

    a_dip_b: assert property (@(posedge sample) dip_b == status[31:24])
        else fail_now($sformatf("CHECK FAILED dip_b exp %h act %h",
            $sampled(status[31:24]), $sampled(dip_b)));

    initial begin
        #(2 * total_cycles * 20);
        fail_now("watchdog expired before the tests finished");
    end

    initial begin
        snd_stereo_t f;
        rng      = 32'h3ff0_18a0;
        arst_n   = 1'b0;
        snd_cen  = 1'b0;
        fm_snd   = '0;
        psg_raw  = '0;
        status   = '0;
        dc_avg   = 0;
        cen_seen = 1'b0;
        exp_head = '0;
        repeat (3) @(posedge sample);
        #2;
        arst_n = 1'b1;
        wait_cycles(4);

        // FM volume, spaced then back-to-back strobes
        for (int lvl = 0; lvl < 4; lvl++) begin
            set_menu(2'(lvl), 1'b1, 1'b0);
            for (int i = 0; i < n_fm_gap + n_fm_b2b; i++) begin
                f = (i == 0) ? {16'sh7fff, 16'sh8000} : next_rand();
                send_sample(f, psg_w'(next_rand()), (i < n_fm_gap) ? 3 : 0);
            end
            wait_cycles(drain);
        end

        // DC removal, step input then noise
        set_menu(2'd0, 1'b0, 1'b1);
        for (int i = 0; i < 2 * n_dc; i++)
            send_sample(next_rand(), (i < n_dc) ? 10'h2a5 : psg_w'(next_rand()), 1);
        wait_cycles(drain);

        // Both sources on with any volume, then both off
        for (int i = 0; i < 2 * n_en; i++) begin
            set_menu(2'(next_rand()), i >= n_en, i >= n_en);
            send_sample(next_rand(), psg_w'(next_rand()), 1);
        end
        wait_cycles(drain);

        check_density(16'sh4000, -16'sh3039);
        check_density(16'sh0000, 16'sh7fff);
        check_density(16'sh8000, 16'sh1234);

        for (int i = 0; i < n_dip; i++) begin
            status = next_rand();
            wait_cycles(1);
        end

        if (exp_q.size() != 0) begin
            fail_now($sformatf("%0d expected mix updates never arrived", exp_q.size()));
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule
